// File: Bender.yml
package:
  name: sms_input

sources:
  # Design, package first
  - logic/sms_input_pkg.sv
  - logic/sms_clock_enables.sv
  - logic/sms_paddle_port.sv
  - logic/sms_port_mux.sv
  - logic/sms_input_top.sv

  # Testbench and bound checker
  - target: test
    files:
      - test/tb_sms_input_checks.sv
      - test/tb_sms_input.sv

// File: logic/sms_clock_enables.sv
/*
 * Clock-enable divider of the input section
 * Counts a 30-step cycle and decodes CPU, VDP, pixel and sound strobes,
 * plus a separate counter for the paddle strobe
 */
`timescale 1ns/1ns
`default_nettype none

module sms_clock_enables (
	input  wire  clk_sys,
	input  wire  arst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp,
	output logic paddle_stb
);
	import sms_input_pkg::*;

	logic [ce_cnt_w-1:0]     cnt;
	logic [paddle_cnt_w-1:0] pad_cnt;
	logic                    vdp_hit;
	logic                    pix_hit;
	logic                    cpu_hit;

	// ====================
	// Divider
	// ====================

	// Slot decode from the current count
	always_comb begin
		vdp_hit = 1'b0;
		pix_hit = 1'b0;
		cpu_hit = 1'b0;
		for (int i = 0; i < $size(vdp_slots); i++) begin
			if (cnt == ce_cnt_w'(vdp_slots[i])) vdp_hit = 1'b1;
		end
		for (int i = 0; i < $size(pix_slots); i++) begin
			if (cnt == ce_cnt_w'(pix_slots[i])) pix_hit = 1'b1;
		end
		for (int i = 0; i < $size(cpu_slots); i++) begin
			if (cnt == ce_cnt_w'(cpu_slots[i])) cpu_hit = 1'b1;
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cnt    <= '0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			cnt    <= (cnt == ce_cnt_w'(ce_cycle_len - 1)) ? '0 : cnt + 1'b1;
			ce_vdp <= vdp_hit;
			ce_pix <= pix_hit;
			ce_cpu <= cpu_hit;
			ce_sp  <= cnt[0]; // Even cycle length, so no glitch at the wrap
		end
	end

	// ====================
	// Paddle strobe
	// ====================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pad_cnt    <= '0;
			paddle_stb <= 1'b0;
		end else begin
			paddle_stb <= (pad_cnt == paddle_cnt_w'(paddle_div - 1));
			if (pad_cnt == paddle_cnt_w'(paddle_div - 1))
				pad_cnt <= '0;
			else
				pad_cnt <= pad_cnt + 1'b1;
		end
	end

	// CPU slots are a subset of the VDP slots
	a_cpu_with_vdp: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce_cpu |-> ce_vdp);

	a_vdp_single: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ce_vdp |=> !ce_vdp);

endmodule

`default_nettype wire

// File: logic/sms_input_pkg.sv
/*
 * Master System controller input section
 * Shared divider constants, strobe slots, port bit positions and types
 */
`default_nettype none

package sms_input_pkg;

	// ====================
	// Clock-enable divider
	// ====================

	localparam int ce_cycle_len = 30;                   // Steps per divider cycle
	localparam int ce_cnt_w     = $clog2(ce_cycle_len); // 5 bits for 0..29

	// Counter values that fire each strobe on the next cycle
	localparam int vdp_slots [6] = '{4, 9, 14, 19, 24, 29}; // Every 5 cycles
	localparam int pix_slots [3] = '{9, 19, 29};            // Every 10 cycles
	localparam int cpu_slots [2] = '{9, 24};                // Every 15 cycles

	// ====================
	// Paddle strobe
	// ====================

	// Roughly 16 kHz from the system clock
	localparam int paddle_div   = 3356;
	localparam int paddle_cnt_w = $clog2(paddle_div); // 12 bits

	// ====================
	// Controller ports
	// ====================

	localparam int port_w    = 8; // One port word
	localparam int nib_w     = 4; // Paddle nibble
	localparam int num_ports = 2;

	// Bit positions inside a port word
	// Bits 0..3 are the directions, bit 4 is fire 1
	localparam int bit_tr    = 5; // Fire 2, paddle trigger / nibble select
	localparam int bit_pause = 6;

	// One port word, active high at the joystick side, active low at the port
	typedef logic [port_w-1:0] port_word_t;

	// Paddle position, high nibble sent second
	typedef logic [2*nib_w-1:0] paddle_t;

endpackage

`default_nettype wire

// File: logic/sms_input_top.sv
/*
 * Controller input section of the Master System core
 * One clock-enable divider, a paddle serializer per port and the port mux
 */
`timescale 1ns/1ns
`default_nettype none

module sms_input_top (
	input  wire                                   clk_sys,
	input  wire                                   arst_n,
	input  wire                                   region,    // High for Japan
	input  wire                                   swap,
	input  wire                                   paddle_en,
	input  sms_input_pkg::port_word_t             joy_0,
	input  sms_input_pkg::port_word_t             joy_1,
	input  sms_input_pkg::paddle_t                paddle_pos [sms_input_pkg::num_ports],
	input  wire [sms_input_pkg::num_ports-1:0]    th_out,
	output logic                                  ce_cpu,
	output logic                                  ce_vdp,
	output logic                                  ce_pix,
	output logic                                  ce_sp,
	output sms_input_pkg::port_word_t             port_a,
	output sms_input_pkg::port_word_t             port_b,
	output logic                                  pause_n
);
	import sms_input_pkg::*;

	logic             paddle_stb;
	logic [nib_w-1:0] nibble [num_ports];
	logic             tr     [num_ports];

	// ====================
	// Clock enables
	// ====================

	sms_clock_enables clk_en_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.ce_cpu     (ce_cpu),
		.ce_vdp     (ce_vdp),
		.ce_pix     (ce_pix),
		.ce_sp      (ce_sp),
		.paddle_stb (paddle_stb)
	);

	// ====================
	// Paddle serializers
	// ====================

	for (genvar p = 0; p < num_ports; p++) begin : g_paddle
		sms_paddle_port paddle_i (
			.clk_sys    (clk_sys),
			.arst_n     (arst_n),
			.paddle_stb (paddle_stb),
			.region     (region),
			.th_out     (th_out[p]),
			.paddle_pos (paddle_pos[p]),
			.nibble     (nibble[p]),
			.tr         (tr[p])
		);
	end

	// Port 0 feeds port A, port 1 feeds port B
	sms_port_mux mux_i (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.swap      (swap),
		.paddle_en (paddle_en),
		.joy_0     (joy_0),
		.joy_1     (joy_1),
		.nibble_a  (nibble[0]),
		.nibble_b  (nibble[1]),
		.tr_a      (tr[0]),
		.tr_b      (tr[1]),
		.port_a    (port_a),
		.port_b    (port_b),
		.pause_n   (pause_n)
	);

endmodule

`default_nettype wire

// File: logic/sms_paddle_port.sv
/*
 * Paddle serializer for one controller port
 * Sends the paddle position as two nibbles, paced by the paddle strobe
 * in Japanese mode or by TH edges in export mode
 */
`timescale 1ns/1ns
`default_nettype none

module sms_paddle_port (
	input  wire                               clk_sys,
	input  wire                               arst_n,
	input  wire                               paddle_stb,
	input  wire                               region,     // High for Japanese mode
	input  wire                               th_out,     // TH driven by the console
	input  sms_input_pkg::paddle_t            paddle_pos,
	output logic [sms_input_pkg::nib_w-1:0]   nibble,
	output logic                              tr
);
	import sms_input_pkg::*;

	logic [nib_w-1:0] nib_hi;   // High nibble held for the second half
	logic             th_s;     // TH input register
	logic             th_q;     // Previous TH for edge detection
	logic             th_rise;
	logic             th_fall;
	logic             load_pos;
	logic             show_hi;

	// ====================
	// TH edge detection
	// ====================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			th_s <= 1'b1; // TH idles high
			th_q <= 1'b1;
		end else begin
			th_s <= th_out;
			th_q <= th_s;
		end
	end

	assign th_rise = ~th_q &  th_s;
	assign th_fall =  th_q & ~th_s;

	// ====================
	// Nibble sequencing
	// ====================

	// Japanese paddle: tr high means the next strobe starts a new position
	// Export: falling TH starts, rising TH finishes
	assign load_pos = region ? (paddle_stb &  tr) : th_fall;
	assign show_hi  = region ? (paddle_stb & ~tr) : th_rise;

	always_ff @(posedge clk_sys) begin
		if (load_pos)
			nib_hi <= paddle_pos[2*nib_w-1:nib_w];
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			nibble <= '0;
			tr     <= 1'b1;
		end else begin
			if (load_pos)
				nibble <= paddle_pos[nib_w-1:0]; // Low nibble first
			else if (show_hi)
				nibble <= nib_hi;

			if (region) begin
				if (paddle_stb)
					tr <= ~tr; // Low with the low nibble, high with the high one
			end else if (th_rise || th_fall) begin
				tr <= 1'b0;
			end
		end
	end

	// Export mode never raises tr once TH has started toggling
	a_export_tr_low: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(!region && (th_rise || th_fall)) |=> (!tr until region));

endmodule

`default_nettype wire

// File: logic/sms_port_mux.sv
/*
 * Controller port mux
 * Swaps the joysticks, inverts them to active-low port words,
 * overlays the paddle nibble and trigger and derives pause
 */
`timescale 1ns/1ns
`default_nettype none

module sms_port_mux (
	input  wire                             clk_sys,
	input  wire                             arst_n,
	input  wire                             swap,
	input  wire                             paddle_en,
	input  sms_input_pkg::port_word_t       joy_0,     // Active high
	input  sms_input_pkg::port_word_t       joy_1,
	input  wire [sms_input_pkg::nib_w-1:0]  nibble_a,
	input  wire [sms_input_pkg::nib_w-1:0]  nibble_b,
	input  wire                             tr_a,
	input  wire                             tr_b,
	output sms_input_pkg::port_word_t       port_a,    // Active low
	output sms_input_pkg::port_word_t       port_b,
	output logic                            pause_n
);
	import sms_input_pkg::*;

	port_word_t sel_a;
	port_word_t sel_b;
	port_word_t word_a;
	port_word_t word_b;

	// ====================
	// Word assembly
	// ====================

	assign sel_a = swap ? joy_1 : joy_0;
	assign sel_b = swap ? joy_0 : joy_1;

	always_comb begin
		word_a = ~sel_a;
		word_b = ~sel_b;

		// Paddle drives the direction lines MSB first
		if (paddle_en) begin
			for (int i = 0; i < nib_w; i++) begin
				word_a[i] = nibble_a[nib_w-1-i];
				word_b[i] = nibble_b[nib_w-1-i];
			end
			word_a[bit_tr] = tr_a;
			word_b[bit_tr] = tr_b;
		end
	end

	// ====================
	// Output registers
	// ====================

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			port_a  <= '1; // Nothing pressed
			port_b  <= '1;
			pause_n <= 1'b1;
		end else begin
			port_a  <= word_a;
			port_b  <= word_b;
			pause_n <= word_a[bit_pause] & word_b[bit_pause]; // Either port pauses
		end
	end

	// Pause comes from both joysticks whatever the swap or paddle setting
	a_pause_and: assert property (@(posedge clk_sys) disable iff (!arst_n)
		1'b1 |=> pause_n == !($past(joy_0[bit_pause]) || $past(joy_1[bit_pause])));

endmodule

`default_nettype wire

// File: sms_input.f
logic/sms_input_pkg.sv
logic/sms_clock_enables.sv
logic/sms_paddle_port.sv
logic/sms_port_mux.sv
logic/sms_input_top.sv
test/tb_sms_input_checks.sv
test/tb_sms_input.sv

// File: test/tb_sms_input.sv
/*
 * Testbench for the controller input section
 * Runs joystick, Japanese paddle and export paddle phases
 * while the bound checker compares the outputs
 */
`timescale 1ns/1ns
`default_nettype none

module tb_sms_input;
	import sms_input_pkg::*;

	localparam int clk_half       = 4;
	localparam int reset_cycles   = 4;
	localparam int joy_cycles     = 300;
	localparam int jp_periods     = 6;   // Paddle strobe periods in Japanese mode
	localparam int th_half        = 20;  // TH toggle interval per port
	localparam int th_edges       = 32;  // Both ports together
	localparam int timeout_cycles = 8 * paddle_div + 2000;

	logic                 clk_sys;
	logic                 arst_n;
	logic                 region;
	logic                 swap;
	logic                 paddle_en;
	port_word_t           joy_0;
	port_word_t           joy_1;
	paddle_t              paddle_pos [num_ports];
	logic [num_ports-1:0] th_out;
	logic                 ce_cpu;
	logic                 ce_vdp;
	logic                 ce_pix;
	logic                 ce_sp;
	port_word_t           port_a;
	port_word_t           port_b;
	logic                 pause_n;
	int unsigned          cycle_cnt = 0;

	sms_input_top dut_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.region     (region),
		.swap       (swap),
		.paddle_en  (paddle_en),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.paddle_pos (paddle_pos),
		.th_out     (th_out),
		.ce_cpu     (ce_cpu),
		.ce_vdp     (ce_vdp),
		.ce_pix     (ce_pix),
		.ce_sp      (ce_sp),
		.port_a     (port_a),
		.port_b     (port_b),
		.pause_n    (pause_n)
	);

	bind sms_input_top tb_sms_input_checks checks_i (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.region     (region),
		.swap       (swap),
		.paddle_en  (paddle_en),
		.joy_0      (joy_0),
		.joy_1      (joy_1),
		.paddle_pos (paddle_pos),
		.th_out     (th_out),
		.ce_cpu     (ce_cpu),
		.ce_vdp     (ce_vdp),
		.ce_pix     (ce_pix),
		.ce_sp      (ce_sp),
		.port_a     (port_a),
		.port_b     (port_b),
		.pause_n    (pause_n)
	);

	initial begin
		clk_sys = 1'b0;
		forever #clk_half clk_sys = ~clk_sys;
	end

	// Ends the run after a failed check or a timeout
	task automatic stop_on_error();
		$display("Done: errors found");
		$fatal(1, "Run stopped on error");
	endtask

	// First failing assertion of the checker
	initial begin
		wait (dut_i.checks_i.error_seen);
		stop_on_error();
	end

	always @(posedge clk_sys) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == timeout_cycles) begin
			$display("Timeout: stimulus did not finish within %0d cycles", timeout_cycles);
			stop_on_error();
		end
	end

	// New random joysticks every cycle, swap flips now and then
	task automatic drive_joysticks();
		joy_0 = port_word_t'($urandom);
		joy_1 = port_word_t'($urandom);
		if ($urandom_range(7) == 0)
			swap = ~swap;
	endtask

	task automatic run_joystick_phase(input int cycles);
		repeat (cycles) begin
			@(negedge clk_sys);
			drive_joysticks();
		end
	endtask

	// Positions stay fixed while the strobe walks through both nibbles
	task automatic run_japanese_phase(input int cycles);
		for (int p = 0; p < num_ports; p++)
			paddle_pos[p] = paddle_t'($urandom);
		region    = 1'b1;
		paddle_en = 1'b1;
		run_joystick_phase(cycles);
	endtask

	// Ports take turns, so each TH toggles every th_half cycles
	task automatic run_export_phase(input int edges);
		for (int p = 0; p < num_ports; p++)
			paddle_pos[p] = paddle_t'($urandom);
		region = 1'b0;
		for (int e = 0; e < edges; e++) begin
			run_joystick_phase(th_half / num_ports);
			th_out[e % num_ports] = ~th_out[e % num_ports];
		end
	endtask

	initial begin
		void'($urandom(32'h352e_9a6f));
		arst_n    = 1'b0;
		region    = 1'b0;
		swap      = 1'b0;
		paddle_en = 1'b0;
		joy_0     = '0;
		joy_1     = '0;
		th_out    = '1; // TH idles high
		for (int p = 0; p < num_ports; p++)
			paddle_pos[p] = '0;

		repeat (reset_cycles) @(posedge clk_sys);
		@(negedge clk_sys);
		arst_n = 1'b1;

		run_joystick_phase(joy_cycles);
		run_japanese_phase(jp_periods * paddle_div);
		run_export_phase(th_edges);
		run_joystick_phase(th_half);

		if (dut_i.checks_i.error_seen) begin
			stop_on_error();
		end else begin
			$display("Done: no errors");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: test/tb_sms_input_checks.sv
/*
 * Assertion checker for the controller input section
 * Rebuilds the expected strobes and port words from the input history
 * and compares them with the outputs of the top level
 */
`timescale 1ns/1ns
`default_nettype none

module tb_sms_input_checks (
	input wire                                clk_sys,
	input wire                                arst_n,
	input wire                                region,
	input wire                                swap,
	input wire                                paddle_en,
	input sms_input_pkg::port_word_t          joy_0,
	input sms_input_pkg::port_word_t          joy_1,
	input sms_input_pkg::paddle_t             paddle_pos [sms_input_pkg::num_ports],
	input wire [sms_input_pkg::num_ports-1:0] th_out,
	input wire                                ce_cpu,
	input wire                                ce_vdp,
	input wire                                ce_pix,
	input wire                                ce_sp,
	input sms_input_pkg::port_word_t          port_a,
	input sms_input_pkg::port_word_t          port_b,
	input wire                                pause_n
);
	import sms_input_pkg::*;

	int unsigned cyc;      // Samples since reset release
	int unsigned jp_run;   // Consecutive samples in Japanese paddle mode
	int unsigned exp_run;  // Same for export paddle mode
	logic        pen_q;
	port_word_t  exp_a;
	port_word_t  exp_b;
	logic        exp_pause_n;
	logic        vdp_due;
	logic        pix_due;
	logic        cpu_due;
	logic        sp_due;
	logic        jp_act;
	logic        exp_act;
	logic        error_seen = 1'b0; // Raised by any failing assertion

	// First pulse one cycle after the counter holds the first slot,
	// then evenly spaced over the divider cycle
	function automatic logic strobe_due(int unsigned c, int first_slot, int slot_cnt);
		int unsigned first;
		int unsigned period;
		first  = first_slot + 1;
		period = ce_cycle_len / slot_cnt;
		return (c >= first) && ((c - first) % period == 0);
	endfunction

	task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
		$error("FAILED at %0t: %s = %0h, expected %0h", $time, name, got, want);
		error_seen = 1'b1;
	endtask

	assign vdp_due = strobe_due(cyc, vdp_slots[0], $size(vdp_slots));
	assign pix_due = strobe_due(cyc, pix_slots[0], $size(pix_slots));
	assign cpu_due = strobe_due(cyc, cpu_slots[0], $size(cpu_slots));
	assign sp_due  = (cyc >= 2) && !cyc[0]; // Registered low bit of the count
	assign jp_act  = region && paddle_en && (jp_run >= 2);
	assign exp_act = !region && paddle_en && (exp_run >= 4);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cyc         <= 0;
			jp_run      <= 0;
			exp_run     <= 0;
			pen_q       <= 1'b0;
			exp_a       <= '1;
			exp_b       <= '1;
			exp_pause_n <= 1'b1;
		end else begin
			cyc         <= cyc + 1;
			jp_run      <= (region && paddle_en) ? jp_run + 1 : 0;
			exp_run     <= (!region && paddle_en) ? exp_run + 1 : 0;
			pen_q       <= paddle_en;
			exp_a       <= ~(swap ? joy_1 : joy_0);
			exp_b       <= ~(swap ? joy_0 : joy_1);
			exp_pause_n <= !(joy_0[bit_pause] || joy_1[bit_pause]); // Either button pauses
		end
	end

	// ====================
	// Strobes and joysticks
	// ====================

	a_vdp: assert property (@(posedge clk_sys) disable iff (!arst_n) ce_vdp == vdp_due)
		else report_mismatch("ce_vdp", $sampled(ce_vdp), $sampled(vdp_due));
	a_pix: assert property (@(posedge clk_sys) disable iff (!arst_n) ce_pix == pix_due)
		else report_mismatch("ce_pix", $sampled(ce_pix), $sampled(pix_due));
	a_cpu: assert property (@(posedge clk_sys) disable iff (!arst_n) ce_cpu == cpu_due)
		else report_mismatch("ce_cpu", $sampled(ce_cpu), $sampled(cpu_due));
	a_sp: assert property (@(posedge clk_sys) disable iff (!arst_n) ce_sp == sp_due)
		else report_mismatch("ce_sp", $sampled(ce_sp), $sampled(sp_due));

	a_reset_ports: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cyc == 0 |-> {port_a, port_b, pause_n} == 17'h1ffff)
		else report_mismatch("port_a/port_b/pause_n",
			$sampled({port_a, port_b, pause_n}), 17'h1ffff);

	a_joy_a: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(cyc != 0 && !pen_q) |-> port_a == exp_a)
		else report_mismatch("port_a", $sampled(port_a), $sampled(exp_a));
	a_joy_b: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(cyc != 0 && !pen_q) |-> port_b == exp_b)
		else report_mismatch("port_b", $sampled(port_b), $sampled(exp_b));
	a_pause: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cyc != 0 |-> pause_n == exp_pause_n)
		else report_mismatch("pause_n", $sampled(pause_n), $sampled(exp_pause_n));

	// ====================
	// Paddle nibbles
	// ====================

	for (genvar p = 0; p < num_ports; p++) begin : g_port
		localparam string port_name = (p == 0) ? "port_a" : "port_b";

		port_word_t       pw;
		logic [nib_w-1:0] nib;
		logic [3:0]       th_hist;  // Bit k holds TH from k+1 samples ago
		logic             tr_q;
		logic             tr_seen;  // Toggle seen in this Japanese run
		logic             th_seen;  // A TH edge has reached the port
		logic             toggled;
		logic             th_fell;
		logic             th_rose;
		int unsigned      tr_gap;

		assign pw      = (p == 0) ? port_a : port_b;
		assign nib     = {pw[0], pw[1], pw[2], pw[3]}; // Port bit 0 is the nibble MSB
		assign toggled = jp_act && (pw[bit_tr] != tr_q);
		// TH change first sampled three samples ago shows up now
		assign th_fell = !th_hist[2] &&  th_hist[3];
		assign th_rose =  th_hist[2] && !th_hist[3];

		always_ff @(posedge clk_sys or negedge arst_n) begin
			if (!arst_n) begin
				th_hist <= '1;
				tr_q    <= 1'b1;
				tr_seen <= 1'b0;
				th_seen <= 1'b0;
				tr_gap  <= 0;
			end else begin
				th_hist <= {th_hist[2:0], th_out[p]};
				tr_q    <= pw[bit_tr];
				tr_gap  <= toggled ? 1 : tr_gap + 1;
				tr_seen <= jp_act && (tr_seen || toggled);
				th_seen <= exp_act && (th_seen || th_fell || th_rose);
			end
		end

		a_jp_low: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(jp_act && !pw[bit_tr]) |-> nib == paddle_pos[p][nib_w-1:0])
			else report_mismatch({port_name, " low nibble"},
				$sampled(nib), $sampled(paddle_pos[p][nib_w-1:0]));
		a_jp_high: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(jp_act && pw[bit_tr] && tr_seen) |-> nib == paddle_pos[p][2*nib_w-1:nib_w])
			else report_mismatch({port_name, " high nibble"},
				$sampled(nib), $sampled(paddle_pos[p][2*nib_w-1:nib_w]));
		a_tr_rate: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(toggled && tr_seen) |-> tr_gap >= paddle_div)
			else report_mismatch({port_name, " tr toggle gap"}, $sampled(tr_gap), paddle_div);

		a_exp_fall: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(exp_act && th_fell) |-> nib == paddle_pos[p][nib_w-1:0])
			else report_mismatch({port_name, " low nibble"},
				$sampled(nib), $sampled(paddle_pos[p][nib_w-1:0]));
		a_exp_rise: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(exp_act && th_rose) |-> nib == paddle_pos[p][2*nib_w-1:nib_w])
			else report_mismatch({port_name, " high nibble"},
				$sampled(nib), $sampled(paddle_pos[p][2*nib_w-1:nib_w]));
		a_exp_tr: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(exp_act && (th_seen || th_fell || th_rose)) |-> !pw[bit_tr])
			else report_mismatch({port_name, " tr"}, $sampled(pw[bit_tr]), 0);
	end

endmodule

`default_nettype wire
